// File: hdl/l2_tag_defines.svh
/*
 * L2 tag directory geometry.
 * Set count, index width, tag width, owner thread width and
 * associativity shared by the directory RTL and its testbench.
 */
`ifndef L2_TAG_DEFINES_SVH
`define L2_TAG_DEFINES_SVH

`define L2_SETS     512     // sets per way
`define L2_INDEX_W  9       // log2 of set count
`define L2_TAG_W    18      // stored address tag
`define L2_THREAD_W 2       // owner hardware thread
`define L2_WAYS     4       // associativity

`endif

// File: hdl/l2_tag_pkg.sv
/*
 * L2 tag directory types.
 * Command opcodes, controller FSM states and the packed
 * lookup/fill response carried from the controller to the top level.
 */
package l2_tag_pkg;
    `include "l2_tag_defines.svh"

    typedef logic [$clog2(`L2_WAYS)-1:0] way_t;   // way number

    typedef enum logic [1:0] {
        op_lookup   = 2'd0,     // tag compare only
        op_fill_l1  = 2'd1,     // dirty write-back from L1
        op_fill_mem = 2'd2      // clean fill from memory
    } tag_op_e;

    typedef enum logic [2:0] {
        st_idle  = 3'd0,
        st_read  = 3'd1,        // set read issued
        st_eval  = 3'd2,        // compare and victim select
        st_write = 3'd3,        // fills only
        st_resp  = 3'd4         // response held until taken
    } ctrl_state_e;

    typedef struct packed {
        logic                      hit;
        way_t                      hit_way;
        logic                      hit_dirty;
        logic [`L2_THREAD_W-1:0]   hit_thread;
        way_t                      victim_way;
        logic [`L2_TAG_W-1:0]      victim_tag;
        logic                      victim_dirty;
        logic                      victim_valid;
    } tag_resp_t;

endpackage

// File: hdl/tag_ram_if.sv
/*
 * Tag RAM access bundle.
 * Controller drives index, read and per-way write enables plus
 * write data; the RAM returns every way of the set one cycle after re.
 */
`timescale 1ns/1ns
`include "l2_tag_defines.svh"

interface tag_ram_if;
    logic [`L2_INDEX_W-1:0]                  index;
    logic                                    re;        // read all ways
    logic [`L2_WAYS-1:0]                     we;        // one-hot on fills
    logic [`L2_TAG_W-1:0]                    wd_tag;
    logic [`L2_THREAD_W-1:0]                 wd_thread;
    logic                                    wd_dirty;
    logic                                    plru_we;
    logic [2:0]                              plru_wd;

    logic [`L2_WAYS-1:0][`L2_TAG_W-1:0]      rd_tag;
    logic [`L2_WAYS-1:0][`L2_THREAD_W-1:0]   rd_thread;
    logic [`L2_WAYS-1:0]                     rd_dirty;
    logic [`L2_WAYS-1:0]                     rd_valid;
    logic [2:0]                              rd_plru;

    modport ctrl (
        output index, re, we, wd_tag, wd_thread, wd_dirty, plru_we, plru_wd,
        input  rd_tag, rd_thread, rd_dirty, rd_valid, rd_plru
    );

    modport ram (
        input  index, re, we, wd_tag, wd_thread, wd_dirty, plru_we, plru_wd,
        output rd_tag, rd_thread, rd_dirty, rd_valid, rd_plru
    );
endinterface

// File: hdl/sp_sram.sv
/*
 * Single-port synchronous SRAM, L2_SETS words deep.
 * Write at the clock edge; read data registered when re is high
 * and held otherwise. No reset, as for a compiled macro.
 */
`timescale 1ns/1ns
`include "l2_tag_defines.svh"

module sp_sram #(
    parameter int WIDTH = 18
) (
    input  logic                   clk,
    input  logic [`L2_INDEX_W-1:0] addr,
    input  logic                   we,
    input  logic                   re,
    input  logic [WIDTH-1:0]       wd,
    output logic [WIDTH-1:0]       rd
);

    logic [WIDTH-1:0] mem [`L2_SETS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wd;
        end
        if (re) begin
            rd <= mem[addr];    // old data on same-cycle write
        end
    end

endmodule

// File: hdl/l2_tag_ram.sv
/*
 * L2 tag RAM.
 * Per-way tag and owner-thread SRAMs, with dirty, valid and the
 * per-set pseudo-LRU field in flop arrays that clear on reset.
 * All fields of a set come back together one cycle after re.
 */
`timescale 1ns/1ns
`include "l2_tag_defines.svh"

module l2_tag_ram (
    input  logic   clk,
    input  logic   rst_n,
    tag_ram_if.ram bus
);

    logic [`L2_WAYS-1:0] valid_q [`L2_SETS];
    logic [`L2_WAYS-1:0] dirty_q [`L2_SETS];
    logic [2:0]          plru_q  [`L2_SETS];

    // one tag and one thread macro per way, sharing index and data
    for (genvar w = 0; w < `L2_WAYS; w++) begin : g_way
        sp_sram #(
            .WIDTH (`L2_TAG_W)
        ) u_tag (
            .clk  (clk),
            .addr (bus.index),
            .we   (bus.we[w]),
            .re   (bus.re),
            .wd   (bus.wd_tag),
            .rd   (bus.rd_tag[w])
        );

        sp_sram #(
            .WIDTH (`L2_THREAD_W)
        ) u_thread (
            .clk  (clk),
            .addr (bus.index),
            .we   (bus.we[w]),
            .re   (bus.re),
            .wd   (bus.wd_thread),
            .rd   (bus.rd_thread[w])
        );
    end

    // state bits that must start known
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < `L2_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                plru_q[s]  <= '0;
            end
        end else begin
            for (int w = 0; w < `L2_WAYS; w++) begin
                if (bus.we[w]) begin
                    valid_q[bus.index][w] <= 1'b1;  // any fill validates
                    dirty_q[bus.index][w] <= bus.wd_dirty;
                end
            end
            if (bus.plru_we) begin
                plru_q[bus.index] <= bus.plru_wd;
            end
        end
    end

    // registered alongside the SRAM outputs
    always_ff @(posedge clk) begin
        if (bus.re) begin
            bus.rd_valid <= valid_q[bus.index];
            bus.rd_dirty <= dirty_q[bus.index];
            bus.rd_plru  <= plru_q[bus.index];
        end
    end

endmodule

// File: hdl/l2_tag_ctrl.sv
/*
 * L2 tag directory controller.
 * Accepts one command at a time, reads the set, compares tags,
 * chooses the replacement victim from valid bits and the tree
 * pseudo-LRU field, writes fills and holds the response until taken.
 */
`timescale 1ns/1ns
`include "l2_tag_defines.svh"

module l2_tag_ctrl
    import l2_tag_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  tag_op_e                 req_op,
    input  logic [`L2_INDEX_W-1:0]  req_index,
    input  logic [`L2_TAG_W-1:0]    req_tag,
    input  logic [`L2_THREAD_W-1:0] req_thread,
    input  way_t                    req_way,
    output logic                    resp_valid,
    input  logic                    resp_ready,
    output tag_resp_t               resp,
    tag_ram_if.ctrl                 bus
);

    ctrl_state_e state, state_nxt;

    // latched command
    tag_op_e                 op_q;
    logic [`L2_INDEX_W-1:0]  index_q;
    logic [`L2_TAG_W-1:0]    tag_q;
    logic [`L2_THREAD_W-1:0] thread_q;
    way_t                    way_q;

    logic [`L2_WAYS-1:0]     match;
    logic                    hit_any;
    way_t                    hit_way;
    way_t                    plru_victim;
    way_t                    victim_way;
    tag_resp_t               resp_d;
    tag_resp_t               resp_q;

    assign req_ready  = (state == st_idle);
    assign resp_valid = (state == st_resp);
    assign resp       = resp_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:  if (req_valid) state_nxt = st_read;
            st_read:  state_nxt = st_eval;
            st_eval:  state_nxt = (op_q == op_lookup) ? st_resp : st_write;
            st_write: state_nxt = st_resp;
            st_resp:  if (resp_ready) state_nxt = st_idle;
            default:  state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            op_q     <= req_op;
            index_q  <= req_index;
            tag_q    <= req_tag;
            thread_q <= req_thread;
            way_q    <= req_way;
        end
    end

    // tag compare, lowest matching way wins
    always_comb begin
        hit_any = 1'b0;
        hit_way = '0;
        for (int w = `L2_WAYS - 1; w >= 0; w--) begin
            match[w] = bus.rd_valid[w] && (bus.rd_tag[w] == tag_q);
            if (match[w]) begin
                hit_any = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    // tree walk, then lowest invalid way overrides
    always_comb begin
        if (bus.rd_plru[0]) begin
            plru_victim = bus.rd_plru[2] ? way_t'(3) : way_t'(2);
        end else begin
            plru_victim = bus.rd_plru[1] ? way_t'(1) : way_t'(0);
        end
        victim_way = plru_victim;
        for (int w = `L2_WAYS - 1; w >= 0; w--) begin
            if (!bus.rd_valid[w]) begin
                victim_way = way_t'(w);
            end
        end
    end

    always_comb begin
        resp_d.hit          = hit_any;
        resp_d.hit_way      = hit_way;
        resp_d.hit_dirty    = hit_any && bus.rd_dirty[hit_way];
        resp_d.hit_thread   = hit_any ? bus.rd_thread[hit_way] : '0;
        resp_d.victim_way   = victim_way;
        resp_d.victim_tag   = bus.rd_tag[victim_way];
        resp_d.victim_dirty = bus.rd_dirty[victim_way];
        resp_d.victim_valid = bus.rd_valid[victim_way];
    end

    // pre-write view of the set, also for fills
    always_ff @(posedge clk) begin
        if (state == st_eval) begin
            resp_q <= resp_d;
        end
    end

    assign bus.index     = index_q;
    assign bus.re        = (state == st_read);
    assign bus.wd_tag    = tag_q;
    assign bus.wd_thread = thread_q;
    assign bus.wd_dirty  = (op_q == op_fill_l1);   // L1 write-back is dirty
    assign bus.plru_we   = (state == st_write);

    always_comb begin
        bus.we = '0;
        if (state == st_write) begin
            bus.we[way_q] = 1'b1;
        end
    end

    // rd_plru still holds the value read for this command
    always_comb begin
        bus.plru_wd = bus.rd_plru;
        case (way_q)
            2'd0: begin
                bus.plru_wd[0] = 1'b1;
                bus.plru_wd[1] = 1'b1;
            end
            2'd1: begin
                bus.plru_wd[0] = 1'b1;
                bus.plru_wd[1] = 1'b0;
            end
            2'd2: begin
                bus.plru_wd[0] = 1'b0;
                bus.plru_wd[2] = 1'b1;
            end
            default: begin
                bus.plru_wd[0] = 1'b0;
                bus.plru_wd[2] = 1'b0;
            end
        endcase
    end

endmodule

// File: hdl/l2_tag_dir.sv
/*
 * L2 tag directory top level.
 * Joins the command controller and the tag RAM and presents the
 * request and response channels as plain ports.
 */
`timescale 1ns/1ns
`include "l2_tag_defines.svh"

module l2_tag_dir
    import l2_tag_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  tag_op_e                 req_op,
    input  logic [`L2_INDEX_W-1:0]  req_index,
    input  logic [`L2_TAG_W-1:0]    req_tag,
    input  logic [`L2_THREAD_W-1:0] req_thread,
    input  way_t                    req_way,
    output logic                    resp_valid,
    input  logic                    resp_ready,
    output logic                    resp_hit,
    output way_t                    resp_way,
    output logic                    resp_dirty,
    output logic [`L2_THREAD_W-1:0] resp_thread,
    output way_t                    resp_victim_way,
    output logic [`L2_TAG_W-1:0]    resp_victim_tag,
    output logic                    resp_victim_dirty,
    output logic                    resp_victim_valid
);

    tag_resp_t resp;
    tag_ram_if ram_bus ();

    l2_tag_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_op     (req_op),
        .req_index  (req_index),
        .req_tag    (req_tag),
        .req_thread (req_thread),
        .req_way    (req_way),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp),
        .bus        (ram_bus.ctrl)
    );

    l2_tag_ram u_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (ram_bus.ram)
    );

    assign resp_hit          = resp.hit;
    assign resp_way          = resp.hit_way;
    assign resp_dirty        = resp.hit_dirty;
    assign resp_thread       = resp.hit_thread;
    assign resp_victim_way   = resp.victim_way;
    assign resp_victim_tag   = resp.victim_tag;
    assign resp_victim_dirty = resp.victim_dirty;
    assign resp_victim_valid = resp.victim_valid;

endmodule

// File: verif/l2_tag_dir_assert.sv
/*
 * L2 tag directory protocol assertions.
 * Response held while stalled, one-hot way writes, no new request
 * during a pending response, and writes only in the fill write state.
 */
`timescale 1ns/1ns
`include "l2_tag_defines.svh"

module l2_tag_dir_assert
    import l2_tag_pkg::*;
(
    input logic                clk,
    input logic                rst_n,
    input logic                req_ready,
    input logic                resp_valid,
    input logic                resp_ready,
    input logic [27:0]         resp_fields,
    input logic [`L2_WAYS-1:0] ram_we,
    input logic                plru_we,
    input ctrl_state_e         state,
    input tag_op_e             op
);

    a_resp_stable: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_fields))
        else $error("response changed or dropped while stalled");

    a_we_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(ram_we))
        else $error("more than one way write enable high");

    a_ready_blocked: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> !req_ready)
        else $error("request channel ready while a response is pending");

    a_write_fill: assert property (@(posedge clk) disable iff (!rst_n)
        (|ram_we || plru_we) |-> (state == st_write && op != op_lookup))
        else $error("tag RAM written outside a fill");

endmodule

bind l2_tag_dir l2_tag_dir_assert u_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_ready   (req_ready),
    .resp_valid  (resp_valid),
    .resp_ready  (resp_ready),
    .resp_fields ({resp_hit, resp_way, resp_dirty, resp_thread, resp_victim_way,
                   resp_victim_tag, resp_victim_dirty, resp_victim_valid}),
    .ram_we      (ram_bus.we),
    .plru_we     (ram_bus.plru_we),
    .state       (u_ctrl.state),
    .op          (u_ctrl.op_q)
);

// File: verif/tb_l2_tag_dir.sv
/*
 * Testbench for the L2 tag directory.
 * Directed lookups and fills, then a seeded random mix over eight
 * sets, with every response checked against a per-set model of
 * tags, owners, dirty and valid bits and the pseudo-LRU tree.
 */
`timescale 1ns/1ns
`include "l2_tag_defines.svh"

module tb_l2_tag_dir
    import l2_tag_pkg::*;
();

    localparam int CLK_PERIOD  = 8;
    localparam int N_RANDOM    = 400;
    localparam int N_CMDS      = 8 + 20 + N_RANDOM;
    localparam int WATCHDOG_NS = (N_CMDS * 12 + 100) * CLK_PERIOD;  // latency plus worst stall

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    req_valid;
    logic                    req_ready;
    tag_op_e                 req_op;
    logic [`L2_INDEX_W-1:0]  req_index;
    logic [`L2_TAG_W-1:0]    req_tag;
    logic [`L2_THREAD_W-1:0] req_thread;
    way_t                    req_way;
    logic                    resp_valid;
    logic                    resp_ready;
    logic                    resp_hit;
    way_t                    resp_way;
    logic                    resp_dirty;
    logic [`L2_THREAD_W-1:0] resp_thread;
    way_t                    resp_victim_way;
    logic [`L2_TAG_W-1:0]    resp_victim_tag;
    logic                    resp_victim_dirty;
    logic                    resp_victim_valid;

    // reference model of the directory contents
    logic [`L2_TAG_W-1:0]    m_tag    [`L2_SETS][`L2_WAYS];
    logic [`L2_THREAD_W-1:0] m_thread [`L2_SETS][`L2_WAYS];
    logic                    m_dirty  [`L2_SETS][`L2_WAYS];
    logic                    m_valid  [`L2_SETS][`L2_WAYS];
    logic [2:0]              m_plru   [`L2_SETS];

    // expected response of the command in flight
    logic                    e_hit;
    way_t                    e_way;
    logic                    e_dirty;
    logic [`L2_THREAD_W-1:0] e_thread;
    way_t                    e_vway;
    logic [`L2_TAG_W-1:0]    e_vtag;
    logic                    e_vdirty;
    logic                    e_vvalid;

    int n_cmds   = 0;
    int n_checks = 0;
    int n_errors = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    l2_tag_dir dut0 (.*);

    function automatic logic [`L2_INDEX_W-1:0] pick_index();
        return {3'($urandom % 8), 6'h15};   // eight sets, high bits vary
    endfunction

    function automatic logic [`L2_TAG_W-1:0] pick_tag();
        return {12'h2b7, 6'($urandom % 6)}; // small pool so tags repeat
    endfunction

    // lowest invalid way first, else walk the tree
    function automatic way_t victim_of(input logic [`L2_INDEX_W-1:0] idx);
        logic [2:0] p;
        p = m_plru[idx];
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (!m_valid[idx][w]) begin
                return way_t'(w);
            end
        end
        if (p[0]) begin
            return p[2] ? way_t'(3) : way_t'(2);
        end
        return p[1] ? way_t'(1) : way_t'(0);
    endfunction

    task automatic predict(input logic [`L2_INDEX_W-1:0] idx, input logic [`L2_TAG_W-1:0] tag);
        e_hit    = 1'b0;
        e_way    = '0;
        e_dirty  = 1'b0;
        e_thread = '0;
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (!e_hit && m_valid[idx][w] && m_tag[idx][w] == tag) begin
                e_hit    = 1'b1;
                e_way    = way_t'(w);
                e_dirty  = m_dirty[idx][w];
                e_thread = m_thread[idx][w];
            end
        end
        e_vway   = victim_of(idx);
        e_vtag   = m_tag[idx][e_vway];
        e_vdirty = m_dirty[idx][e_vway];
        e_vvalid = m_valid[idx][e_vway];
    endtask

    task automatic model_fill(input tag_op_e op, input logic [`L2_INDEX_W-1:0] idx,
                              input logic [`L2_TAG_W-1:0] tag,
                              input logic [`L2_THREAD_W-1:0] thr, input way_t way);
        logic [2:0] p;
        p = m_plru[idx];
        m_tag[idx][way]    = tag;
        m_thread[idx][way] = thr;
        m_dirty[idx][way]  = (op == op_fill_l1);
        m_valid[idx][way]  = 1'b1;
        case (way)
            2'd0:    m_plru[idx] = {p[2], 2'b11};
            2'd1:    m_plru[idx] = {p[2], 2'b01};
            2'd2:    m_plru[idx] = {1'b1, p[1], 1'b0};
            default: m_plru[idx] = {1'b0, p[1], 1'b0};
        endcase
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_resp();
        compare_field("hit", 32'(resp_hit), 32'(e_hit));
        if (e_hit) begin
            compare_field("hit way", 32'(resp_way), 32'(e_way));
            compare_field("hit dirty", 32'(resp_dirty), 32'(e_dirty));
            compare_field("hit thread", 32'(resp_thread), 32'(e_thread));
        end
        compare_field("victim way", 32'(resp_victim_way), 32'(e_vway));
        compare_field("victim valid", 32'(resp_victim_valid), 32'(e_vvalid));
        compare_field("victim dirty", 32'(resp_victim_dirty), 32'(e_vdirty));
        if (e_vvalid) begin
            compare_field("victim tag", 32'(resp_victim_tag), 32'(e_vtag));
        end
    endtask

    // starts and ends on a falling edge with the DUT idle
    task automatic run_cmd(input tag_op_e op, input logic [`L2_INDEX_W-1:0] idx,
                           input logic [`L2_TAG_W-1:0] tag,
                           input logic [`L2_THREAD_W-1:0] thr, input way_t way);
        int cyc;
        int stall;
        n_cmds++;
        predict(idx, tag);
        if (op != op_lookup) begin
            model_fill(op, idx, tag, thr, way);
        end
        stall = ($urandom % 4 == 0) ? 1 + int'($urandom % 3) : 0;
        if (!req_ready) begin
            n_errors++;
            $display("error at %0t: request channel not ready while idle", $time);
        end
        req_valid  = 1'b1;
        req_op     = op;
        req_index  = idx;
        req_tag    = tag;
        req_thread = thr;
        req_way    = way;
        resp_ready = (stall == 0);  // high throughout unless this one stalls
        @(negedge clk);
        req_valid = 1'b0;
        cyc = 1;
        while (!resp_valid && cyc < 20) begin
            @(negedge clk);
            cyc++;
        end
        if (!resp_valid) begin
            n_errors++;
            $display("error at %0t: no response within 20 cycles", $time);
        end else begin
            compare_field("latency", 32'(cyc), (op == op_lookup) ? 32'd3 : 32'd4);
            check_resp();
            repeat (stall) begin
                req_valid = 1'b1;       // probe while stalled
                req_tag   = ~tag;
                @(negedge clk);
                if (req_ready || !resp_valid) begin
                    n_errors++;
                    $display("error at %0t: stalled response dropped or request taken", $time);
                end
                check_resp();
            end
            req_valid  = 1'b0;
            resp_ready = 1'b1;
            @(negedge clk);
            resp_ready = 1'b0;
            if (resp_valid) begin
                n_errors++;
                $display("error at %0t: response still valid after it was taken", $time);
            end
        end
    endtask

    initial begin
        tag_op_e                op;
        logic [`L2_INDEX_W-1:0] idx;
        logic [`L2_TAG_W-1:0]   tag;
        way_t                   way;
        void'($urandom(3));
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req_op     = op_lookup;
        req_index  = '0;
        req_tag    = '0;
        req_thread = '0;
        req_way    = '0;
        resp_ready = 1'b0;
        for (int s = 0; s < `L2_SETS; s++) begin
            m_plru[s] = '0;
            for (int w = 0; w < `L2_WAYS; w++) begin
                m_tag[s][w]    = '0;
                m_thread[s][w] = '0;
                m_dirty[s][w]  = 1'b0;
                m_valid[s][w]  = 1'b0;
            end
        end
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        // empty directory, every set misses
        for (int s = 0; s < 8; s++) begin
            run_cmd(op_lookup, {3'(s), 6'h15}, pick_tag(), 2'd0, 2'd0);
        end

        // fill one set way by way, then evict through the tree
        idx = {3'd5, 6'h15};
        for (int k = 0; k < 4; k++) begin
            tag = {12'h0a1, 6'(k)};
            run_cmd((k % 2 == 1) ? op_fill_l1 : op_fill_mem, idx, tag, 2'(k), victim_of(idx));
            run_cmd(op_lookup, idx, tag, 2'd0, 2'd0);
        end
        for (int k = 0; k < 6; k++) begin
            run_cmd(op_lookup, idx, {12'h3c0, 6'(k)}, 2'd0, 2'd0);  // absent tag
            run_cmd((k % 2 == 0) ? op_fill_l1 : op_fill_mem, idx, {12'h0a2, 6'(k)},
                    2'(k), victim_of(idx));
        end

        // mixed random traffic
        for (int i = 0; i < N_RANDOM; i++) begin
            op  = tag_op_e'(2'($urandom % 3));
            idx = pick_index();
            way = ($urandom % 2 == 0) ? victim_of(idx) : way_t'($urandom % 4);
            run_cmd(op, idx, pick_tag(), 2'($urandom % 4), way);
        end

        $display("commands: %0d, checks: %0d, errors: %0d", n_cmds, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: build.f
+incdir+hdl
hdl/l2_tag_pkg.sv
hdl/tag_ram_if.sv
hdl/sp_sram.sv
hdl/l2_tag_ram.sv
hdl/l2_tag_ctrl.sv
hdl/l2_tag_dir.sv
verif/l2_tag_dir_assert.sv
verif/tb_l2_tag_dir.sv

// File: run_sim.sh
#!/bin/sh
# Build the L2 tag directory testbench with Verilator and run it.
# Exits non-zero if the build or run fails or the log reports errors.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_l2_tag_dir -o tb_l2_tag_dir \
    && ./obj_dir/tb_l2_tag_dir > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "simulation build or run failed"; exit 1; }

cat sim.log
grep -q "Done: errors found" sim.log && exit 1 || exit 0
